//--- design/rchk_cfg_pkg.sv
/* sizing constants for the receive checker
   beat width, lane split and beat fifo depth */
package rchk_cfg_pkg;

	//----------------------------------------------------------------------
	// beat format
	//----------------------------------------------------------------------
	localparam int BEAT_W     = 64;  // data bits per beat
	localparam int LANES      = 2;   // 32-bit lanes per beat
	localparam int LANE_W     = 32;
	localparam int BEAT_CTL_W = 8;   // one control bit per byte

	//----------------------------------------------------------------------
	// beat fifo
	//----------------------------------------------------------------------
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_CNT_W = 5;   // holds 0 .. FIFO_DEPTH

endpackage

//--- design/rchk_pkt_pkg.sv
/* packet format definitions for the receive checker
   control characters, crc constants, word types and demux states */
package rchk_pkt_pkg;

	// pcs control characters, valid only with the byte's control bit set
	typedef enum logic [7:0] {
		IDLE  = 8'h07,
		START = 8'hFB,
		TERM  = 8'hFD
	} pcs_char_e;

	//----------------------------------------------------------------------
	// preamble and crc
	//----------------------------------------------------------------------
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE      = 8'hD5;

	localparam logic [31:0] CRC_POLY    = 32'hEDB8_8320;  // reflected form
	localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;
	// register after a good fcs, msb-first bit order
	localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

	//----------------------------------------------------------------------
	// lane words
	//----------------------------------------------------------------------
	typedef logic [rchk_cfg_pkg::LANE_W-1:0] lane_word_t;
	typedef logic [rchk_cfg_pkg::BEAT_CTL_W/rchk_cfg_pkg::LANES-1:0] lane_ctl_t;

	typedef logic [2:0] bytes_vld_t;  // 1 to 4 bytes in the last word

	// lane walk of the demux
	typedef enum logic [1:0] {
		LANE_HI,  // upper lane of head beat
		LANE_LO,  // lower lane, pops the beat
		DRAIN     // flush a held eop word
	} demux_state_e;

endpackage

//--- design/rchk_beat_if.sv
/* buffered beat path from capture stage through the beat fifo to the demux */
`timescale 1ns/100ps

interface rchk_beat_if;

	// push side
	logic                                push;
	logic [rchk_cfg_pkg::BEAT_W-1:0]     beat_data;
	logic [rchk_cfg_pkg::BEAT_CTL_W-1:0] beat_ctl;

	// pop side, head beat valid while empty is low
	logic                                pop;
	logic                                empty;
	logic [rchk_cfg_pkg::BEAT_W-1:0]     q_data;
	logic [rchk_cfg_pkg::BEAT_CTL_W-1:0] q_ctl;

	modport capture (
		output push, beat_data, beat_ctl
	);

	modport fifo (
		input  push, beat_data, beat_ctl, pop,
		output empty, q_data, q_ctl
	);

	modport demux (
		input  empty, q_data, q_ctl,
		output pop
	);

endinterface

//--- design/rchk_word_if.sv
/* packet words from the lane demux to the packet checker, no ready */
`timescale 1ns/100ps

interface rchk_word_if;

	logic                     vld;
	logic                     sop;        // first word after sfd
	logic                     eop;
	rchk_pkt_pkg::lane_word_t data;       // byte lane 3 first on the wire
	rchk_pkt_pkg::bytes_vld_t bytes_vld;  // meaningful with eop

	modport source (
		output vld, sop, eop, data, bytes_vld
	);

	modport sink (
		input vld, sop, eop, data, bytes_vld
	);

endinterface

//--- design/rchk_rx_capture.sv
/* input register stage, pushes each valid pcs beat into the beat fifo */
`timescale 1ns/100ps

module rchk_rx_capture (
	input  logic                                clk,
	input  logic                                arst_n_i,
	input  logic                                rx_vld_i,
	input  logic [rchk_cfg_pkg::BEAT_W-1:0]     rx_data_i,
	input  logic [rchk_cfg_pkg::BEAT_CTL_W-1:0] rx_ctl_i,
	rchk_beat_if.capture                        beat
);

	logic                                vld_q;
	logic [rchk_cfg_pkg::BEAT_W-1:0]     data_q;
	logic [rchk_cfg_pkg::BEAT_CTL_W-1:0] ctl_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			vld_q <= 1'b0;
		end else begin
			vld_q <= rx_vld_i;
		end
	end

	// beat payload, only loaded with a valid beat
	always_ff @(posedge clk) begin
		if (rx_vld_i) begin
			data_q <= rx_data_i;
			ctl_q  <= rx_ctl_i;
		end
	end

	assign beat.push      = vld_q;
	assign beat.beat_data = data_q;
	assign beat.beat_ctl  = ctl_q;

endmodule

//--- design/rchk_beat_fifo.sv
/* first-word-fall-through beat fifo, head beat shown while not empty
   a push into a full fifo is dropped */
`timescale 1ns/100ps

module rchk_beat_fifo (
	input  logic      clk,
	input  logic      arst_n_i,
	rchk_beat_if.fifo beat
);

	logic [rchk_cfg_pkg::BEAT_W-1:0]     mem_data [rchk_cfg_pkg::FIFO_DEPTH];
	logic [rchk_cfg_pkg::BEAT_CTL_W-1:0] mem_ctl  [rchk_cfg_pkg::FIFO_DEPTH];

	logic [rchk_cfg_pkg::FIFO_CNT_W-2:0] wr_ptr;  // wraps at FIFO_DEPTH
	logic [rchk_cfg_pkg::FIFO_CNT_W-2:0] rd_ptr;
	logic [rchk_cfg_pkg::FIFO_CNT_W-1:0] cnt;
	logic                                full;
	logic                                wr_en;
	logic                                rd_en;

	assign full  = cnt[rchk_cfg_pkg::FIFO_CNT_W-1];  // count equals depth
	assign wr_en = beat.push & ~full;
	assign rd_en = beat.pop & ~beat.empty;

	//----------------------------------------------------------------------
	// pointers and occupancy
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   cnt <= cnt + 1'b1;
				2'b01:   cnt <= cnt - 1'b1;
				default: cnt <= cnt;  // idle or push with pop
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_data[wr_ptr] <= beat.beat_data;
			mem_ctl[wr_ptr]  <= beat.beat_ctl;
		end
	end

	// head beat falls through
	assign beat.empty  = (cnt == '0);
	assign beat.q_data = mem_data[rd_ptr];
	assign beat.q_ctl  = mem_ctl[rd_ptr];

endmodule

//--- design/rchk_lane_demux.sv
/* walks each head beat lane by lane, finds start, sfd and terminate
   and emits packet words one word late so a lane 3 terminate can close */
`timescale 1ns/100ps

module rchk_lane_demux (
	input  logic        clk,
	input  logic        arst_n_i,
	rchk_beat_if.demux  beat,
	rchk_word_if.source word
);

	rchk_pkt_pkg::demux_state_e state;
	rchk_pkt_pkg::demux_state_e state_nxt;
	rchk_pkt_pkg::lane_word_t   lane_data;
	rchk_pkt_pkg::lane_ctl_t    lane_ctl;
	rchk_pkt_pkg::lane_ctl_t    term_vec;
	rchk_pkt_pkg::bytes_vld_t   eop_bytes;
	rchk_pkt_pkg::lane_word_t   hold_data;
	rchk_pkt_pkg::bytes_vld_t   hold_bytes;

	logic lane_go;
	logic start_det;
	logic term_det;
	logic sfd_det;
	logic sfd_hit;
	logic term_close;  // lane 3 terminate closes the held word
	logic term_new;    // terminate word itself becomes the held eop
	logic data_new;
	logic load_hold;
	logic emit;
	logic in_pkt;
	logic sop_pend;
	logic after_start;
	logic hold_vld;
	logic hold_sop;
	logic hold_eop;

	//----------------------------------------------------------------------
	// lane select and character detection
	//----------------------------------------------------------------------
	assign lane_go  = ~beat.empty & (state != rchk_pkt_pkg::DRAIN);
	assign lane_data = (state == rchk_pkt_pkg::LANE_LO) ?
		beat.q_data[rchk_cfg_pkg::LANE_W-1:0] :
		beat.q_data[rchk_cfg_pkg::BEAT_W-1:rchk_cfg_pkg::LANE_W];
	assign lane_ctl = (state == rchk_pkt_pkg::LANE_LO) ?
		beat.q_ctl[$bits(rchk_pkt_pkg::lane_ctl_t)-1:0] :
		beat.q_ctl[rchk_cfg_pkg::BEAT_CTL_W-1 -: $bits(rchk_pkt_pkg::lane_ctl_t)];

	always_comb begin
		for (int i = 0; i < $bits(rchk_pkt_pkg::lane_ctl_t); i++) begin
			term_vec[i] = lane_ctl[i] & (lane_data[8*i +: 8] == rchk_pkt_pkg::TERM);
		end
		// earliest terminate on the wire wins
		if (term_vec[2])
			eop_bytes = 3'd1;
		else if (term_vec[1])
			eop_bytes = 3'd2;
		else if (term_vec[0])
			eop_bytes = 3'd3;
		else
			eop_bytes = 3'd4;  // lane 3, or no terminate
	end

	assign start_det = lane_ctl[3] & (lane_data[31:24] == rchk_pkt_pkg::START);
	assign term_det  = |term_vec;
	assign sfd_det   = (lane_ctl == '0) & (lane_data == {{3{rchk_pkt_pkg::PREAMBLE_BYTE}},
		rchk_pkt_pkg::SFD_BYTE});
	assign sfd_hit   = lane_go & after_start & sfd_det;

	assign term_close = lane_go & term_det & in_pkt & term_vec[3] & hold_vld;
	assign term_new   = lane_go & term_det & ~term_close;
	assign data_new   = lane_go & in_pkt & ~term_det & ~start_det & (lane_ctl != '1);
	assign load_hold  = term_new | data_new;
	assign emit       = (state == rchk_pkt_pkg::DRAIN) |
		(hold_vld & (term_close | load_hold | (lane_go & start_det)));

	// lower lane pops, an upper lane terminate pops early
	assign beat.pop = lane_go & ((state == rchk_pkt_pkg::LANE_LO) | term_det);

	//----------------------------------------------------------------------
	// lane walk
	//----------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			rchk_pkt_pkg::LANE_HI: begin
				if (lane_go)
					state_nxt = term_new ? rchk_pkt_pkg::DRAIN :
						(term_det ? rchk_pkt_pkg::LANE_HI : rchk_pkt_pkg::LANE_LO);
			end
			rchk_pkt_pkg::LANE_LO: begin
				if (lane_go)
					state_nxt = term_new ? rchk_pkt_pkg::DRAIN : rchk_pkt_pkg::LANE_HI;
			end
			default: state_nxt = rchk_pkt_pkg::LANE_HI;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state       <= rchk_pkt_pkg::LANE_HI;
			in_pkt      <= 1'b0;
			sop_pend    <= 1'b0;
			after_start <= 1'b0;
			hold_vld    <= 1'b0;
			hold_sop    <= 1'b0;
			hold_eop    <= 1'b0;
			word.vld    <= 1'b0;
			word.sop    <= 1'b0;
			word.eop    <= 1'b0;
		end else begin
			state <= state_nxt;
			if (lane_go)
				after_start <= start_det;
			if (lane_go & (term_det | start_det))
				in_pkt <= 1'b0;  // start without terminate abandons the packet
			else if (sfd_hit)
				in_pkt <= 1'b1;
			if (sfd_hit)
				sop_pend <= 1'b1;
			else if (load_hold | (lane_go & start_det))
				sop_pend <= 1'b0;
			if (load_hold) begin
				hold_vld <= 1'b1;
				hold_sop <= sop_pend;
				hold_eop <= term_new;
			end else if (emit) begin
				hold_vld <= 1'b0;
			end
			word.vld <= emit;
			word.sop <= emit & hold_sop;
			word.eop <= emit & (hold_eop | term_close);
		end
	end

	// held word and output payload
	always_ff @(posedge clk) begin
		if (load_hold) begin
			hold_data  <= lane_data;
			hold_bytes <= term_new ? eop_bytes : 3'd4;
		end
		if (emit) begin
			word.data      <= hold_data;
			word.bytes_vld <= hold_bytes;
		end
	end

endmodule

//--- design/rchk_pkt_check.sv
/* tracks open packets, checks the crc32 residue at eop
   and pulses the per-packet statistic events */
`timescale 1ns/100ps

module rchk_pkt_check (
	input  logic      clk,
	input  logic      arst_n_i,
	rchk_word_if.sink word,
	output logic      crc32_ok_o,
	output logic      crc32_err_o,
	output logic      inc_rx_sop_o,
	output logic      inc_rx_eop_o,
	output logic      inc_rx_pkt_o,
	output logic      inc_rx_miss_sop_o,
	output logic      inc_rx_miss_eop_o
);

	logic        pkt_open;
	logic        chk_q;  // eop of a packet with a valid sop
	logic        sop_q;
	logic        eop_q;
	logic        miss_sop_q;
	logic        miss_eop_q;
	logic [31:0] crc_q;
	logic [31:0] crc_rev;

	//----------------------------------------------------------------------
	// crc32, bytes in wire order, each byte lsb first
	//----------------------------------------------------------------------
	function automatic logic [31:0] crc_byte(input logic [31:0] crc_in,
		input logic [7:0] byte_in);
		logic [31:0] crc;
		crc = crc_in ^ {24'd0, byte_in};
		for (int i = 0; i < 8; i++) begin
			crc = crc[0] ? ((crc >> 1) ^ rchk_pkt_pkg::CRC_POLY) : (crc >> 1);
		end
		return crc;
	endfunction

	function automatic logic [31:0] crc_word(input logic [31:0] crc_in,
		input rchk_pkt_pkg::lane_word_t data, input rchk_pkt_pkg::bytes_vld_t nbytes);
		logic [31:0] crc;
		crc = crc_in;
		for (int b = 0; b < 4; b++) begin
			if (b < int'(nbytes))
				crc = crc_byte(crc, data[31-8*b -: 8]);  // byte lane 3 first
		end
		return crc;
	endfunction

	// running crc, only meaningful inside a packet
	always_ff @(posedge clk) begin
		if (word.vld & (word.sop | pkt_open))
			crc_q <= crc_word(word.sop ? rchk_pkt_pkg::CRC_INIT : crc_q, word.data,
				word.bytes_vld);
	end

	// residue constant is msb first, register is reflected
	always_comb begin
		for (int i = 0; i < 32; i++) begin
			crc_rev[i] = crc_q[31-i];
		end
	end

	//----------------------------------------------------------------------
	// packet tracking, stage 1 events and stage 2 pulses
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pkt_open          <= 1'b0;
			chk_q             <= 1'b0;
			sop_q             <= 1'b0;
			eop_q             <= 1'b0;
			miss_sop_q        <= 1'b0;
			miss_eop_q        <= 1'b0;
			crc32_ok_o        <= 1'b0;
			crc32_err_o       <= 1'b0;
			inc_rx_sop_o      <= 1'b0;
			inc_rx_eop_o      <= 1'b0;
			inc_rx_pkt_o      <= 1'b0;
			inc_rx_miss_sop_o <= 1'b0;
			inc_rx_miss_eop_o <= 1'b0;
		end else begin
			if (word.vld & word.eop)
				pkt_open <= 1'b0;
			else if (word.vld & word.sop)
				pkt_open <= 1'b1;
			chk_q      <= word.vld & word.eop & (word.sop | pkt_open);
			sop_q      <= word.vld & word.sop;
			eop_q      <= word.vld & word.eop;
			miss_sop_q <= word.vld & word.eop & ~word.sop & ~pkt_open;
			miss_eop_q <= word.vld & word.sop & pkt_open;  // old packet dropped, no crc

			crc32_ok_o        <= chk_q & (crc_rev == rchk_pkt_pkg::CRC_RESIDUE);
			crc32_err_o       <= chk_q & (crc_rev != rchk_pkt_pkg::CRC_RESIDUE);
			inc_rx_sop_o      <= sop_q;
			inc_rx_eop_o      <= eop_q;
			inc_rx_pkt_o      <= chk_q;
			inc_rx_miss_sop_o <= miss_sop_q;
			inc_rx_miss_eop_o <= miss_eop_q;
		end
	end

endmodule

//--- design/rchk_top.sv
/* receive packet checker top, capture -> beat fifo -> lane demux -> crc check */
`timescale 1ns/100ps

module rchk_top (
	input  logic                                clk,
	input  logic                                arst_n_i,
	input  logic                                rx_vld_i,
	input  logic [rchk_cfg_pkg::BEAT_W-1:0]     rx_data_i,
	input  logic [rchk_cfg_pkg::BEAT_CTL_W-1:0] rx_ctl_i,
	output logic                                crc32_ok_o,
	output logic                                crc32_err_o,
	output logic                                inc_rx_sop_o,
	output logic                                inc_rx_eop_o,
	output logic                                inc_rx_pkt_o,
	output logic                                inc_rx_miss_sop_o,
	output logic                                inc_rx_miss_eop_o
);

	rchk_beat_if beat_if ();
	rchk_word_if word_if ();

	rchk_rx_capture rchk_rx_capture_inst (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.rx_vld_i  (rx_vld_i),
		.rx_data_i (rx_data_i),
		.rx_ctl_i  (rx_ctl_i),
		.beat      (beat_if.capture)
	);

	rchk_beat_fifo rchk_beat_fifo_inst (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.beat     (beat_if.fifo)
	);

	rchk_lane_demux rchk_lane_demux_inst (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.beat     (beat_if.demux),
		.word     (word_if.source)
	);

	rchk_pkt_check rchk_pkt_check_inst (
		.clk               (clk),
		.arst_n_i          (arst_n_i),
		.word              (word_if.sink),
		.crc32_ok_o        (crc32_ok_o),
		.crc32_err_o       (crc32_err_o),
		.inc_rx_sop_o      (inc_rx_sop_o),
		.inc_rx_eop_o      (inc_rx_eop_o),
		.inc_rx_pkt_o      (inc_rx_pkt_o),
		.inc_rx_miss_sop_o (inc_rx_miss_sop_o),
		.inc_rx_miss_eop_o (inc_rx_miss_eop_o)
	);

endmodule

//--- testbench/rchk_checker.sv
/* bound assertions on the beat fifo handshake and the result pulses */
`timescale 1ns/100ps

module rchk_checker (
	input logic clk,
	input logic arst_n_i,
	input logic push_i,
	input logic full_i,
	input logic pop_i,
	input logic empty_i,
	input logic crc32_ok_i,
	input logic crc32_err_i,
	input logic inc_rx_sop_i,
	input logic inc_rx_eop_i,
	input logic inc_rx_pkt_i,
	input logic inc_rx_miss_sop_i,
	input logic inc_rx_miss_eop_i
);

	int unsigned fail_cnt = 0;  // assertion failures so far
	logic [6:0]  outs;

	assign outs = {crc32_ok_i, crc32_err_i, inc_rx_sop_i, inc_rx_eop_i, inc_rx_pkt_i,
		inc_rx_miss_sop_i, inc_rx_miss_eop_i};

	//----------------------------------------------------------------------
	// fifo handshake
	//----------------------------------------------------------------------
	no_push_full: assert property (@(posedge clk) disable iff (!arst_n_i) !(push_i && full_i))
		else begin
			fail_cnt++;
			$error("beat pushed into a full FIFO, beat lost");
		end

	no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n_i) !(pop_i && empty_i))
		else begin
			fail_cnt++;
			$error("pop issued while the FIFO is empty");
		end

	//----------------------------------------------------------------------
	// result pulses
	//----------------------------------------------------------------------
	ok_err_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(crc32_ok_i && crc32_err_i))
		else begin
			fail_cnt++;
			$error("crc ok and crc error high together");
		end

	quiet_in_reset: assert property (@(posedge clk) !arst_n_i |-> (outs == '0))
		else begin
			fail_cnt++;
			$error("output high during reset");
		end

	pkt_with_eop: assert property (@(posedge clk) disable iff (!arst_n_i)
		inc_rx_pkt_i |-> inc_rx_eop_i)
		else begin
			fail_cnt++;
			$error("packet pulse without eop pulse");
		end

endmodule

bind rchk_top rchk_checker rchk_checker_inst (
	.clk               (clk),
	.arst_n_i          (arst_n_i),
	.push_i            (beat_if.push),
	.full_i            (rchk_beat_fifo_inst.full),
	.pop_i             (beat_if.pop),
	.empty_i           (beat_if.empty),
	.crc32_ok_i        (crc32_ok_o),
	.crc32_err_i       (crc32_err_o),
	.inc_rx_sop_i      (inc_rx_sop_o),
	.inc_rx_eop_i      (inc_rx_eop_o),
	.inc_rx_pkt_i      (inc_rx_pkt_o),
	.inc_rx_miss_sop_i (inc_rx_miss_sop_o),
	.inc_rx_miss_eop_i (inc_rx_miss_eop_o)
);

//--- testbench/rchk_tb.sv
/* testbench for the receive packet checker
   drives pcs beats, counts result pulses and compares them with expected counts */
`timescale 1ns/100ps

module rchk_tb;

	typedef logic [7:0] byte_q_t [$];

	logic                                clk;
	logic                                arst_n_i;
	logic                                rx_vld_i;
	logic [rchk_cfg_pkg::BEAT_W-1:0]     rx_data_i;
	logic [rchk_cfg_pkg::BEAT_CTL_W-1:0] rx_ctl_i;
	logic                                crc32_ok_o;
	logic                                crc32_err_o;
	logic                                inc_rx_sop_o;
	logic                                inc_rx_eop_o;
	logic                                inc_rx_pkt_o;
	logic                                inc_rx_miss_sop_o;
	logic                                inc_rx_miss_eop_o;

	integer  seed;
	int      cnt [7] = '{default: 0};  // ok, err, sop, eop, pkt, miss_sop, miss_eop
	int      base [7];
	string   cnt_name [7] = '{"crc32_ok", "crc32_err", "rx_sop", "rx_eop", "rx_pkt",
		"rx_miss_sop", "rx_miss_eop"};
	int      test_errs;
	int      n_pass;
	int      n_fail;
	byte_q_t pay;

	rchk_top rchk_top_inst (
		.clk               (clk),
		.arst_n_i          (arst_n_i),
		.rx_vld_i          (rx_vld_i),
		.rx_data_i         (rx_data_i),
		.rx_ctl_i          (rx_ctl_i),
		.crc32_ok_o        (crc32_ok_o),
		.crc32_err_o       (crc32_err_o),
		.inc_rx_sop_o      (inc_rx_sop_o),
		.inc_rx_eop_o      (inc_rx_eop_o),
		.inc_rx_pkt_o      (inc_rx_pkt_o),
		.inc_rx_miss_sop_o (inc_rx_miss_sop_o),
		.inc_rx_miss_eop_o (inc_rx_miss_eop_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// outputs are registered, values before the edge are the settled ones
	always @(posedge clk) begin
		cnt[0] <= cnt[0] + int'(crc32_ok_o);
		cnt[1] <= cnt[1] + int'(crc32_err_o);
		cnt[2] <= cnt[2] + int'(inc_rx_sop_o);
		cnt[3] <= cnt[3] + int'(inc_rx_eop_o);
		cnt[4] <= cnt[4] + int'(inc_rx_pkt_o);
		cnt[5] <= cnt[5] + int'(inc_rx_miss_sop_o);
		cnt[6] <= cnt[6] + int'(inc_rx_miss_eop_o);
	end

	//----------------------------------------------------------------------
	// reference fcs and packet stimulus
	//----------------------------------------------------------------------
	// ethernet fcs, reflected crc32 bit by bit, complemented
	function automatic logic [31:0] eth_fcs(input byte_q_t data);
		logic [31:0] crc;
		logic        fb;
		crc = 32'hFFFF_FFFF;
		foreach (data[i]) begin
			for (int k = 0; k < 8; k++) begin
				fb  = crc[0] ^ data[i][k];
				crc = {1'b0, crc[31:1]} ^ (fb ? 32'hEDB8_8320 : 32'h0);
			end
		end
		return ~crc;
	endfunction

	task automatic drive_beat(input logic [63:0] d, input logic [7:0] c);
		@(negedge clk);
		rx_vld_i  = 1'b1;
		rx_data_i = d;
		rx_ctl_i  = c;
		@(negedge clk);
		rx_vld_i  = 1'b0;  // idle cycle after every beat
	endtask

	task automatic send_idle_beat();
		drive_beat({8{rchk_pkt_pkg::IDLE}}, 8'hFF);
	endtask

	task automatic random_payload(input int len, output byte_q_t p);
		p = {};
		for (int i = 0; i < len; i++)
			p.push_back(8'($random(seed)));
	endtask

	task automatic send_packet(input byte_q_t payload, input bit corrupt, input bit drop_term);
		byte_q_t                             wire_b;
		bit                                  wire_c [$];
		logic [31:0]                         fcs;
		logic [rchk_cfg_pkg::BEAT_W-1:0]     d;
		logic [rchk_cfg_pkg::BEAT_CTL_W-1:0] c;
		fcs = eth_fcs(payload);
		wire_b.push_back(rchk_pkt_pkg::START);
		wire_c.push_back(1'b1);
		for (int i = 0; i < 7; i++) begin
			wire_b.push_back(i == 6 ? rchk_pkt_pkg::SFD_BYTE : rchk_pkt_pkg::PREAMBLE_BYTE);
			wire_c.push_back(1'b0);
		end
		foreach (payload[i]) begin
			wire_b.push_back(payload[i]);
			wire_c.push_back(1'b0);
		end
		for (int i = 0; i < 4; i++) begin
			wire_b.push_back(fcs[8*i +: 8]);  // low fcs byte first
			wire_c.push_back(1'b0);
		end
		if (corrupt)
			wire_b[8] = wire_b[8] ^ 8'h01;  // first payload byte
		wire_b.push_back(drop_term ? rchk_pkt_pkg::IDLE : rchk_pkt_pkg::TERM);
		wire_c.push_back(1'b1);
		while (wire_b.size() % 8 != 0) begin
			wire_b.push_back(rchk_pkt_pkg::IDLE);
			wire_c.push_back(1'b1);
		end
		for (int j = 0; j < wire_b.size() / 8; j++) begin
			for (int k = 0; k < 8; k++) begin
				d[63-8*k -: 8] = wire_b[8*j+k];  // first wire byte in the top bits
				c[7-k]         = wire_c[8*j+k];
			end
			drive_beat(d, c);
		end
	endtask

	//----------------------------------------------------------------------
	// checking
	//----------------------------------------------------------------------
	task automatic start_test();
		base      = cnt;
		test_errs = 0;
	endtask

	task automatic expect_eq(input string what, input int got, input int exp_val);
		assert (got == exp_val) else begin
			$display("mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, exp_val);
			test_errs++;
		end
	endtask

	task automatic check_counts(input int e_ok, e_err, e_sop, e_eop, e_pkt, e_msop, e_meop);
		int exp_cnt [7];
		exp_cnt = '{e_ok, e_err, e_sop, e_eop, e_pkt, e_msop, e_meop};
		for (int i = 0; i < 7; i++)
			expect_eq(cnt_name[i], cnt[i] - base[i], exp_cnt[i]);
	endtask

	// wait for crc results and eop pulses, then a short quiet window
	task automatic wait_results(input int crc_n, input int eop_n, input string what);
		int t;
		t = 0;
		while ((cnt[0] + cnt[1] - base[0] - base[1] < crc_n || cnt[3] - base[3] < eop_n)
			&& t < 3000) begin
			@(negedge clk);
			t++;
		end
		if (t >= 3000) begin
			$display("timeout at %0d ns: %s never came", $time, what);
			test_errs++;
		end
		for (int i = 0; i < 8; i++)
			@(negedge clk);
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0) begin
			n_pass++;
			$display("%s: pass", name);
		end else begin
			n_fail++;
			$display("%s: %0d errors", name, test_errs);
		end
	endtask

	initial begin
		int len;
		seed      = 32'h443b_2236;
		arst_n_i  = 1'b0;
		rx_vld_i  = 1'b0;
		rx_data_i = '0;
		rx_ctl_i  = '0;
		n_pass    = 0;
		n_fail    = 0;

		start_test();
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			expect_eq("outputs in reset", int'({crc32_ok_o, crc32_err_o, inc_rx_sop_o,
				inc_rx_eop_o, inc_rx_pkt_o, inc_rx_miss_sop_o, inc_rx_miss_eop_o}), 0);
		end
		arst_n_i = 1'b1;
		for (int i = 0; i < 8; i++)
			@(negedge clk);
		check_counts(0, 0, 0, 0, 0, 0, 0);
		finish_test("reset");

		// terminate in byte k of the beat, all four byte lanes in both beat lanes
		start_test();
		for (int k = 0; k < 8; k++) begin
			len = 8 * (($random(seed) & 7) + 2) + k - 4;
			random_payload(len, pay);
			send_packet(pay, 1'b0, 1'b0);
			send_idle_beat();
		end
		wait_results(8, 8, "crc result of a good packet");
		check_counts(8, 0, 8, 8, 8, 0, 0);
		finish_test("good_packets");

		start_test();
		random_payload(1 + ($random(seed) & 63), pay);
		send_packet(pay, 1'b1, 1'b0);
		send_idle_beat();
		wait_results(1, 1, "crc result of the corrupted packet");
		check_counts(0, 1, 1, 1, 1, 0, 0);
		finish_test("bad_fcs");

		start_test();
		random_payload(1 + ($random(seed) & 63), pay);
		send_packet(pay, 1'b0, 1'b1);
		send_idle_beat();
		random_payload(1 + ($random(seed) & 63), pay);
		send_packet(pay, 1'b0, 1'b0);
		send_idle_beat();
		wait_results(1, 1, "crc result after the missing terminate");
		check_counts(1, 0, 2, 1, 1, 0, 1);
		finish_test("missing_terminate");

		start_test();
		drive_beat({rchk_pkt_pkg::TERM, {7{rchk_pkt_pkg::IDLE}}}, 8'hFF);
		send_idle_beat();
		wait_results(0, 1, "eop of the stray terminate");
		check_counts(0, 0, 0, 1, 0, 1, 0);
		finish_test("stray_terminate");

		start_test();
		for (int n = 0; n < 20; n++) begin
			random_payload(1 + ($random(seed) & 63), pay);
			send_packet(pay, 1'b0, 1'b0);
			send_idle_beat();
		end
		wait_results(20, 20, "crc result in the packet stream");
		check_counts(20, 0, 20, 20, 20, 0, 0);
		finish_test("back_to_back");

		$display("summary: %0d tests passed, %0d tests with errors, %0d checker failures",
			n_pass, n_fail, rchk_top_inst.rchk_checker_inst.fail_cnt);
		if (n_fail == 0 && rchk_top_inst.rchk_checker_inst.fail_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- tb.f
design/rchk_cfg_pkg.sv
design/rchk_pkt_pkg.sv
design/rchk_beat_if.sv
design/rchk_word_if.sv
design/rchk_rx_capture.sv
design/rchk_beat_fifo.sv
design/rchk_lane_demux.sv
design/rchk_pkt_check.sv
design/rchk_top.sv
testbench/rchk_checker.sv
testbench/rchk_tb.sv

//--- Makefile
# Verilator simulation of the receive packet checker

TOP = rchk_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails unless the run passes"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	@grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
